//--- build.f
+incdir+include
hdl/trs_ctrl_pkg.sv
hdl/esp_spi_slave.sv
hdl/cmd_parser.sv
hdl/cmd_regs.sv
hdl/flash_spi_master.sv
hdl/trs_ctrl_top.sv
verif/tb_trs_ctrl.sv

//--- hdl/cmd_parser.sv
`timescale 1ns/100ps

`include "trs_ctrl_cfg.svh"

module cmd_parser (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  trs_ctrl_pkg::byte_t       rx_byte,
  input  logic                      byte_valid,
  output logic                      action,
  output trs_ctrl_pkg::cmd_e        cmd,
  output trs_ctrl_pkg::param_bank_t params,
  output logic                      bad_opcode
);
  import trs_ctrl_pkg::*;

  // wide enough for counts 0..TRS_MAX_PARAMS
  localparam int CNT_W = $clog2(`TRS_MAX_PARAMS + 1);

  parse_state_e     state;
  logic [CNT_W-1:0] remaining;
  logic [CNT_W-1:0] idx;
  logic             op_known;
  logic [CNT_W-1:0] op_params;

  // opcode table
  always_comb begin
    op_known  = 1'b1;
    op_params = '0;
    case (rx_byte)
      get_cookie,
      get_version,
      get_mode,
      get_config,
      get_spi_data: begin
        op_params = '0;
      end
      set_led,
      set_spi_ctrl_reg,
      set_spi_data,
      set_esp_status: begin
        op_params = CNT_W'(1);
      end
      set_screen_color: begin
        op_params = CNT_W'(3);
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= idle;
      cmd        <= get_cookie;
      params     <= '0;
      remaining  <= '0;
      idx        <= '0;
      action     <= 1'b0;
      bad_opcode <= 1'b0;
    end else begin
      action     <= 1'b0;
      bad_opcode <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            idx <= '0;
            if (!op_known) begin
              // dropped or garbage opcode, stay in idle
              bad_opcode <= 1'b1;
            end else begin
              cmd <= cmd_e'(rx_byte);
              if (op_params == '0) begin
                action <= 1'b1;
              end else begin
                remaining <= op_params;
                state     <= read_bytes;
              end
            end
          end
          read_bytes: begin
            params[idx*8 +: 8] <= rx_byte;
            idx                <= idx + CNT_W'(1);
            if (remaining == CNT_W'(1)) begin
              action <= 1'b1;
              state  <= idle;
            end else begin
              remaining <= remaining - CNT_W'(1);
            end
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

endmodule

//--- hdl/cmd_regs.sv
`timescale 1ns/100ps

`include "trs_ctrl_cfg.svh"

module cmd_regs (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      action,
  input  trs_ctrl_pkg::cmd_e        cmd,
  input  trs_ctrl_pkg::param_bank_t params,
  input  logic                      bad_opcode,
  input  logic [3:0]                conf,
  input  trs_ctrl_pkg::byte_t       flash_data,
  output trs_ctrl_pkg::byte_t       tx_byte,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue,
  output logic                      led_error,
  output trs_ctrl_pkg::byte_t       esp_status,
  output trs_ctrl_pkg::rgb_t        screen_rgb
);
  import trs_ctrl_pkg::*;

  byte_t      param0;
  logic [3:0] mode_nibble;

  assign param0 = params[7:0];

  // switch off on conf[3] reports the mode plus 8
  assign mode_nibble = `TRS_BOARD_MODE +
                       ((`TRS_ADD_DIP_4 && !conf[3]) ? 4'd8 : 4'd0);

  // write commands
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red    <= 1'b0;
      led_green  <= 1'b0;
      led_blue   <= 1'b0;
      esp_status <= '0;
      screen_rgb <= 24'hFFFFFF;
    end else if (action) begin
      case (cmd)
        set_led: begin
          led_red   <= param0[0];
          led_green <= param0[1];
          led_blue  <= param0[2];
        end
        set_esp_status: begin
          esp_status <= param0;
        end
        set_screen_color: begin
          screen_rgb <= {params[7:0], params[15:8], params[23:16]};
        end
        default: begin
        end
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_error <= 1'b0;
    end else if (bad_opcode) begin
      led_error <= 1'b1;
    end
  end

  // response byte, picked up by the slave at the next byte boundary
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_byte <= '0;
    end else if (action) begin
      case (cmd)
        get_cookie:   tx_byte <= `TRS_COOKIE;
        get_version:  tx_byte <= {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
        get_config:   tx_byte <= {4'b0000, ~conf};
        get_mode:     tx_byte <= {4'b0000, mode_nibble};
        get_spi_data: tx_byte <= flash_data;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hdl/esp_spi_slave.sv
`timescale 1ns/100ps

module esp_spi_slave (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  logic                cs_n,
  input  logic                sck,
  input  logic                mosi,
  input  trs_ctrl_pkg::byte_t tx_byte,
  output logic                miso,
  output trs_ctrl_pkg::byte_t rx_byte,
  output logic                byte_valid
);
  import trs_ctrl_pkg::*;

  logic [2:0] sck_r;
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      rx_shift;
  byte_t      tx_shift;

  // two flop synchronisers, third sck stage feeds the edge detect
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r    <= '0;
      cs_r     <= '1;
      mosi_r   <= '0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_r    <= {sck_r[1:0], sck};
      cs_r     <= {cs_r[0], cs_n};
      mosi_r   <= {mosi_r[0], mosi};
      sck_rise <= (sck_r[2:1] == 2'b01);
      sck_fall <= (sck_r[2:1] == 2'b10);
    end
  end

  assign cs_active = ~cs_r[1];

  // mode 0: sample on rise, shift out on fall
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= '0;
      rx_shift   <= '0;
      tx_shift   <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt    <= bit_cnt + 3'd1;
          rx_shift   <= {rx_shift[6:0], mosi_r[1]};
          byte_valid <= (bit_cnt == 3'd7);
        end
        if (sck_fall) begin
          // count wrapped to 0, so this fall ends a byte
          if (bit_cnt == 3'd0) begin
            tx_shift <= tx_byte;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active ? tx_shift[7] : 1'bz;

endmodule

//--- hdl/flash_spi_master.sv
`timescale 1ns/100ps

`include "trs_ctrl_cfg.svh"

module flash_spi_master (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      action,
  input  trs_ctrl_pkg::cmd_e        cmd,
  input  trs_ctrl_pkg::param_bank_t params,
  input  logic                      flash_so,
  output trs_ctrl_pkg::byte_t       flash_data,
  output logic                      flash_cs_n,
  output logic                      flash_clk,
  output logic                      flash_si
);
  import trs_ctrl_pkg::*;

  localparam int PH_W     = $clog2(`TRS_FLASH_BIT_CLKS);
  localparam int HALF     = `TRS_FLASH_BIT_CLKS / 2;
  localparam int SAMPLE   = HALF + HALF / 2 - 1;
  localparam int LAST_PH  = `TRS_FLASH_BIT_CLKS - 1;

  // only bit 7 of the control byte is implemented, chip select
  logic          cs_bit;
  logic          busy;
  logic [PH_W+2:0] cnt;
  logic [PH_W-1:0] phase;
  byte_t         shift_reg;

  assign phase = cnt[PH_W-1:0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cs_bit    <= 1'b0;
      busy      <= 1'b0;
      cnt       <= '0;
      shift_reg <= '0;
      flash_si  <= 1'b0;
    end else begin
      if (action && cmd == set_spi_ctrl_reg) begin
        cs_bit <= params[7];
      end
      if (busy) begin
        cnt <= cnt + 1'b1;
        // receive at mid high half, present next bit as the low half starts
        if (phase == PH_W'(SAMPLE)) begin
          shift_reg <= {shift_reg[6:0], flash_so};
        end
        if (phase == PH_W'(LAST_PH)) begin
          flash_si <= (&cnt) ? 1'b0 : shift_reg[7];
          busy     <= ~(&cnt);
        end
      end else if (action && cmd == set_spi_data) begin
        shift_reg <= params[7:0];
        flash_si  <= params[7];
        cnt       <= '0;
        busy      <= 1'b1;
      end
    end
  end

  assign flash_clk  = busy && (phase >= PH_W'(HALF));
  assign flash_cs_n = ~cs_bit;
  assign flash_data = shift_reg;

endmodule

//--- hdl/trs_ctrl_pkg.sv
`include "trs_ctrl_cfg.svh"

package trs_ctrl_pkg;

  // one byte on the ESP link
  typedef logic [7:0] byte_t;

  // screen colour, red in the top byte
  typedef logic [23:0] rgb_t;

  // parameter 0 sits in the low byte
  typedef logic [8*`TRS_MAX_PARAMS-1:0] param_bank_t;

  // ESP opcodes, values shared with the ESP firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    get_mode         = 8'd16,
    set_screen_color = 8'd17,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32
  } cmd_e;

  // command parser states
  typedef enum logic [0:0] {
    idle       = 1'b0,
    read_bytes = 1'b1
  } parse_state_e;

endpackage

//--- hdl/trs_ctrl_top.sv
`timescale 1ns/100ps

module trs_ctrl_top (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  logic                cs_fpga,
  input  logic                sck,
  input  logic                mosi,
  output logic                miso,
  input  logic [3:0]          conf,
  output logic                led_red,
  output logic                led_green,
  output logic                led_blue,
  output logic                led_error,
  output trs_ctrl_pkg::byte_t esp_status,
  output trs_ctrl_pkg::rgb_t  screen_rgb,
  output logic                flash_cs_n,
  output logic                flash_clk,
  output logic                flash_si,
  input  logic                flash_so
);
  import trs_ctrl_pkg::*;

  byte_t       rx_byte;
  byte_t       tx_byte;
  byte_t       flash_data;
  logic        byte_valid;
  logic        action;
  logic        bad_opcode;
  cmd_e        cmd;
  param_bank_t params;

  esp_spi_slave u_spi (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .cs_n(cs_fpga), .sck(sck),
    .mosi(mosi), .tx_byte(tx_byte), .miso(miso), .rx_byte(rx_byte),
    .byte_valid(byte_valid)
  );

  cmd_parser u_parser (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .rx_byte(rx_byte),
    .byte_valid(byte_valid), .action(action), .cmd(cmd), .params(params),
    .bad_opcode(bad_opcode)
  );

  cmd_regs u_regs (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .action(action), .cmd(cmd),
    .params(params), .bad_opcode(bad_opcode), .conf(conf), .flash_data(flash_data),
    .tx_byte(tx_byte), .led_red(led_red), .led_green(led_green), .led_blue(led_blue),
    .led_error(led_error), .esp_status(esp_status), .screen_rgb(screen_rgb)
  );

  flash_spi_master u_flash (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .action(action), .cmd(cmd),
    .params(params), .flash_so(flash_so), .flash_data(flash_data),
    .flash_cs_n(flash_cs_n), .flash_clk(flash_clk), .flash_si(flash_si)
  );

endmodule

//--- include/trs_ctrl_cfg.svh
`ifndef TRS_CTRL_CFG_SVH
`define TRS_CTRL_CFG_SVH

// answer to get_cookie, lets the ESP find the FPGA
`define TRS_COOKIE 8'hAF

// get_version byte is {major, minor}
`define TRS_VERSION_MAJOR 3'd0
`define TRS_VERSION_MINOR 5'd3

// fixed board mode reported by get_mode
`define TRS_BOARD_MODE 4'd1

// conf[3] off adds 8 to the reported mode
`define TRS_ADD_DIP_4 1'b1

// widest parameter list of any opcode
`define TRS_MAX_PARAMS 3

// clk cycles per flash bit, low half then high half
`define TRS_FLASH_BIT_CLKS 16

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
set -e

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_trs_ctrl

# the simulator exits non-zero on failure, the log decides the result
./obj_dir/Vtb_trs_ctrl > "$log" 2>&1 || true
cat "$log"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q '\*\*\* TEST PASSED \*\*\*' "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- verif/tb_trs_ctrl.sv
`timescale 1ns/100ps

`include "trs_ctrl_cfg.svh"

module tb_trs_ctrl;

  localparam int timeout_cycles = 40000;

  // opcodes as the ESP sends them
  localparam logic [7:0] op_get_cookie       = 8'd0;
  localparam logic [7:0] op_get_version      = 8'd15;
  localparam logic [7:0] op_get_mode         = 8'd16;
  localparam logic [7:0] op_set_screen_color = 8'd17;
  localparam logic [7:0] op_set_led          = 8'd26;
  localparam logic [7:0] op_get_config       = 8'd27;
  localparam logic [7:0] op_set_spi_ctrl_reg = 8'd29;
  localparam logic [7:0] op_set_spi_data     = 8'd30;
  localparam logic [7:0] op_get_spi_data     = 8'd31;
  localparam logic [7:0] op_set_esp_status   = 8'd32;
  // opcode that the parser no longer knows
  localparam logic [7:0] op_dropped          = 8'd20;

  logic        clk;
  logic        cass_out_sel_n;
  logic        cs_fpga;
  logic        sck;
  logic        mosi;
  wire         miso;
  logic [3:0]  conf;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  logic        led_error;
  logic [7:0]  esp_status;
  logic [23:0] screen_rgb;
  logic        flash_cs_n;
  logic        flash_clk;
  logic        flash_si;
  wire         flash_so;

  logic [31:0] lfsr_state = 32'd67428;
  int          cycle_count = 0;
  int          fail_count = 0;

  // pending comparisons for the checker process
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];

  // flash device model
  logic [7:0]  flash_preload = 8'h00;
  logic [7:0]  flash_rx = 8'h00;
  int          flash_falls = 0;

  trs_ctrl_top dut (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n), .cs_fpga(cs_fpga), .sck(sck),
    .mosi(mosi), .miso(miso), .conf(conf), .led_red(led_red), .led_green(led_green),
    .led_blue(led_blue), .led_error(led_error), .esp_status(esp_status),
    .screen_rgb(screen_rgb), .flash_cs_n(flash_cs_n), .flash_clk(flash_clk),
    .flash_si(flash_si), .flash_so(flash_so)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // preload goes out MSB first, one bit per falling flash clock
  assign flash_so = (!flash_cs_n && flash_falls < 8) ? flash_preload[7 - flash_falls] : 1'b0;

  always @(posedge flash_clk) begin
    if (!flash_cs_n) begin
      flash_rx <= {flash_rx[6:0], flash_si};
    end
  end

  always @(negedge flash_clk) begin
    if (!flash_cs_n) begin
      flash_falls <= flash_falls + 1;
    end
  end

  // right shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // response byte that a read opcode should return
  function automatic logic [7:0] expected_response(input logic [7:0] op,
                                                   input logic [3:0] conf_v,
                                                   input logic [7:0] flash_v);
    logic [3:0] mode;
    mode = `TRS_BOARD_MODE;
    if (`TRS_ADD_DIP_4 && !conf_v[3]) begin
      mode = mode + 4'd8;
    end
    case (op)
      op_get_cookie:   expected_response = `TRS_COOKIE;
      op_get_version:  expected_response = {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
      op_get_config:   expected_response = {4'h0, ~conf_v};
      op_get_mode:     expected_response = {4'h0, mode};
      op_get_spi_data: expected_response = flash_v;
      default:         expected_response = 8'h00;
    endcase
  endfunction

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      fail_count = fail_count + 1;
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  always @(posedge clk) begin
    while (act_q.size() != 0) begin
      compare_values(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run still going after %0d clock cycles", timeout_cycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  // inputs change just after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0 host with 8 clk per SCK half period
  task automatic spi_exchange(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] got;
    got = '0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(8);
      got = {got[6:0], miso};
      sck = 1'b1;
      wait_cycles(8);
      sck = 1'b0;
    end
    rx = got;
  endtask

  task automatic send_byte(input logic [7:0] tx);
    logic [7:0] ignored;
    spi_exchange(tx, ignored);
  endtask

  // response comes back during the filler byte
  task automatic read_and_check(input logic [7:0] op, input string name);
    logic [7:0] resp;
    send_byte(op);
    spi_exchange(op_get_cookie, resp);
    expect_value(name, expected_response(op, conf, flash_preload), resp);
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  p0;
    logic [7:0]  p1;
    logic [7:0]  p2;
    logic [7:0]  data_byte;

    cass_out_sel_n = 1'b0;
    cs_fpga = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    conf = 4'h0;
    wait_cycles(10);
    cass_out_sel_n = 1'b1;
    wait_cycles(2);

    expect_value("led_red", 0, led_red);
    expect_value("led_green", 0, led_green);
    expect_value("led_blue", 0, led_blue);
    expect_value("led_error", 0, led_error);
    expect_value("esp_status", 0, esp_status);
    expect_value("screen_rgb", 24'hFFFFFF, screen_rgb);
    expect_value("flash_cs_n", 1, flash_cs_n);
    expect_value("flash_clk", 0, flash_clk);

    // CS stays low for the rest of the run
    cs_fpga = 1'b0;
    wait_cycles(4);

    for (int pass_idx = 0; pass_idx < 4; pass_idx++) begin
      if (pass_idx == 0) begin
        conf = 4'h0;
      end else begin
        r = random_bits(4);
        conf = r[3:0];
      end
      read_and_check(op_get_cookie, "get_cookie");
      read_and_check(op_get_version, "get_version");
      read_and_check(op_get_config, "get_config");
      read_and_check(op_get_mode, "get_mode");
    end

    // second write flips every LED bit
    r = random_bits(8);
    for (int k = 0; k < 2; k++) begin
      p0 = (k == 0) ? r[7:0] : ~r[7:0];
      send_byte(op_set_led);
      send_byte(p0);
      send_byte(op_get_cookie);
      expect_value("led_red", p0[0], led_red);
      expect_value("led_green", p0[1], led_green);
      expect_value("led_blue", p0[2], led_blue);
    end

    r = random_bits(8);
    p0 = r[7:0];
    send_byte(op_set_esp_status);
    send_byte(p0);
    send_byte(op_get_cookie);
    expect_value("esp_status", p0, esp_status);

    r = random_bits(24);
    p0 = r[23:16];
    p1 = r[15:8];
    p2 = r[7:0];
    send_byte(op_set_screen_color);
    send_byte(p0);
    send_byte(p1);
    send_byte(p2);
    send_byte(op_get_cookie);
    expect_value("screen_rgb", {p0, p1, p2}, screen_rgb);

    // select the flash and run one full duplex byte
    send_byte(op_set_spi_ctrl_reg);
    send_byte(8'h80);
    send_byte(op_get_cookie);
    expect_value("flash_cs_n", 0, flash_cs_n);

    r = random_bits(16);
    flash_preload = r[15:8];
    data_byte = r[7:0];
    send_byte(op_set_spi_data);
    send_byte(data_byte);
    wait_cycles(140);
    expect_value("flash_rx", data_byte, flash_rx);
    expect_value("flash_clk", 0, flash_clk);
    read_and_check(op_get_spi_data, "get_spi_data");

    send_byte(op_set_spi_ctrl_reg);
    send_byte(8'h00);
    send_byte(op_get_cookie);
    expect_value("flash_cs_n", 1, flash_cs_n);

    // unknown opcode sets the sticky error and the parser resyncs
    send_byte(op_dropped);
    read_and_check(op_get_cookie, "get_cookie after unknown opcode");
    expect_value("led_error", 1, led_error);
    read_and_check(op_get_version, "get_version after unknown opcode");
    expect_value("led_error", 1, led_error);

    wait_cycles(3);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
